// File: hdl/aesCipher.sv
/*
 * Iterative AES-128 encryption core, one round per clock.
 * A seed accepted while idle is encrypted under the package key with the
 * round keys expanded on the fly. The ciphertext stays on cipherBlock with
 * cipherValid high until the consumer takes it, and only then does the
 * core accept the next seed.
 */

`timescale 1ns/1ps

module aesCipher import prngPkg::*; (
    input  logic     Clock,
    input  logic     arstN,
    input  logic     seedValid,
    output logic     seedReady,
    input  aesBlockT seed,
    output logic     cipherValid,
    input  logic     cipherReady,
    output aesBlockT cipherBlock
);

    logic [1:0]  fsmState;
    logic [3:0]  round;
    aesBlockT    state;
    aesBlockT    roundKey;
    logic [7:0]  rcon;
    aesBlockT    shifted;
    aesBlockT    mixed;
    aesBlockT    nextState;
    aesBlockT    nextKey;
    logic [31:0] keyTemp;

    // Multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [31:0] mixColumn(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // ========================================================================
    // Round datapath
    // ========================================================================

    // SubBytes and ShiftRows together, row r rotates left by r columns
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted.bytes[4*c + r] = sbox(state.bytes[4*((c + r) % 4) + r]);
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            mixed.cols[c] = mixColumn(shifted.cols[c]);
        end
    end

    // Round 0 is the initial AddRoundKey, the last round has no MixColumns
    always_comb begin
        if (round == 4'd0) begin
            nextState = state ^ roundKey;
        end else if (round == AesRounds) begin
            nextState = shifted ^ roundKey;
        end else begin
            nextState = mixed ^ roundKey;
        end
    end

    // Next round key from RotWord, SubWord and the round constant
    always_comb begin
        keyTemp = {sbox(roundKey.bytes[13]), sbox(roundKey.bytes[14]),
                   sbox(roundKey.bytes[15]), sbox(roundKey.bytes[12])};
        keyTemp = keyTemp ^ {rcon, 24'h000000};
        nextKey.cols[0] = roundKey.cols[0] ^ keyTemp;
        nextKey.cols[1] = roundKey.cols[1] ^ nextKey.cols[0];
        nextKey.cols[2] = roundKey.cols[2] ^ nextKey.cols[1];
        nextKey.cols[3] = roundKey.cols[3] ^ nextKey.cols[2];
    end

    // ========================================================================
    // Control
    // ========================================================================

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            fsmState <= CipherIdle;
            round    <= '0;
        end else begin
            case (fsmState)
                CipherIdle: begin
                    if (seedValid) begin
                        fsmState <= CipherBusy;
                        round    <= '0;
                    end
                end
                CipherBusy: begin
                    round <= round + 4'd1;
                    if (round == AesRounds) begin
                        fsmState <= CipherDone;
                    end
                end
                CipherDone: begin
                    if (cipherReady) begin
                        fsmState <= CipherIdle;
                    end
                end
                default: fsmState <= CipherIdle;
            endcase
        end
    end

    // The round constant doubles in GF(2^8) as each key is derived
    always_ff @(posedge Clock) begin
        if (fsmState == CipherIdle && seedValid) begin
            state    <= seed;
            roundKey <= AesKey;
            rcon     <= 8'h01;
        end else if (fsmState == CipherBusy) begin
            state    <= nextState;
            roundKey <= nextKey;
            rcon     <= xtime(rcon);
        end
    end

    assign seedReady   = (fsmState == CipherIdle);
    assign cipherValid = (fsmState == CipherDone);
    assign cipherBlock = state;

endmodule

// File: hdl/blockBuffer.sv
/*
 * Two-entry ready/valid FIFO for ciphertext blocks.
 * Lets the cipher start its next block while the funnel still drains
 * earlier words. Accepts and releases in the same cycle.
 */

`timescale 1ns/1ps

module blockBuffer import prngPkg::*; (
    input  logic     Clock,
    input  logic     arstN,
    input  logic     inValid,
    output logic     inReady,
    input  aesBlockT inBlock,
    output logic     outValid,
    input  logic     outReady,
    output aesBlockT outBlock
);

    aesBlockT                         mem [0:BufferDepth-1];
    logic [$clog2(BufferDepth)-1:0]   wrPtr;
    logic [$clog2(BufferDepth)-1:0]   rdPtr;
    logic [$clog2(BufferDepth):0]     fill;
    logic                             doWrite;
    logic                             doRead;

    assign inReady  = (fill < BufferDepth);
    assign outValid = (fill != '0);
    assign outBlock = mem[rdPtr];

    assign doWrite = inValid && inReady;
    assign doRead  = outValid && outReady;

    always_ff @(posedge Clock) begin
        if (doWrite) begin
            mem[wrPtr] <= inBlock;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doWrite && !doRead) begin
                fill <= fill + 1'b1;
            end else if (doRead && !doWrite) begin
                fill <= fill - 1'b1;
            end
        end
    end

endmodule

// File: hdl/prng.sv
/*
 * Top level of the AES counter-mode pseudo-random number generator.
 * Chains the seed counter, the cipher core, the block buffer and the
 * output funnel. Random words leave on a valid/ready stream.
 */

`timescale 1ns/1ps

module prng import prngPkg::*; (
    input  logic                 Clock,
    input  logic                 arstN,
    input  logic                 RandOutReady,
    output logic                 RandOutValid,
    output logic [RandWidth-1:0] RandOut
);

    logic     seedValid;
    logic     seedReady;
    aesBlockT seed;
    logic     cipherValid;
    logic     cipherReady;
    aesBlockT cipherBlock;
    logic     bufValid;
    logic     bufReady;
    aesBlockT bufBlock;

    seedCounter u_seedCounter (
        .Clock(Clock), .arstN(arstN),
        .seedValid(seedValid), .seedReady(seedReady), .seed(seed)
    );

    aesCipher u_aesCipher (
        .Clock(Clock), .arstN(arstN),
        .seedValid(seedValid), .seedReady(seedReady), .seed(seed),
        .cipherValid(cipherValid), .cipherReady(cipherReady), .cipherBlock(cipherBlock)
    );

    blockBuffer u_blockBuffer (
        .Clock(Clock), .arstN(arstN),
        .inValid(cipherValid), .inReady(cipherReady), .inBlock(cipherBlock),
        .outValid(bufValid), .outReady(bufReady), .outBlock(bufBlock)
    );

    randFunnel u_randFunnel (
        .Clock(Clock), .arstN(arstN),
        .inValid(bufValid), .inReady(bufReady), .inBlock(bufBlock),
        .RandOutValid(RandOutValid), .RandOutReady(RandOutReady), .RandOut(RandOut)
    );

endmodule

// File: hdl/prngPkg.sv
/*
 * Shared definitions for the AES counter-mode random number generator.
 * Holds the stream widths, the AES-128 round count, the fixed key, the
 * FSM encodings of the cipher core, the S-box lookup and the block union.
 * Modules take it with a wildcard import in their headers.
 */

package prngPkg;

    // ========================================================================
    // Widths and counts
    // ========================================================================

    localparam int AesWidth      = 128;
    localparam int RandWidth     = 32;
    localparam int WordsPerBlock = AesWidth / RandWidth;
    localparam int WordIdxWidth  = $clog2(WordsPerBlock);
    localparam int SeedWidth     = 64;
    localparam int AesRounds     = 10;
    localparam int BufferDepth   = 2;

    // Fixed cipher key, never renewed
    localparam logic [AesWidth-1:0] AesKey = 128'hd840e1a8_dccae7ec_d91f6148_7af2cb73;

    // States of the iterative cipher core
    localparam logic [1:0] CipherIdle = 2'd0;
    localparam logic [1:0] CipherBusy = 2'd1;
    localparam logic [1:0] CipherDone = 2'd2;

    // ========================================================================
    // Cipher block
    // ========================================================================

    // Byte view serves SubBytes and ShiftRows, column view serves MixColumns,
    // the key schedule and the split into output words
    typedef union packed {
        logic [0:AesWidth/8-1][7:0]              bytes;
        logic [0:WordsPerBlock-1][RandWidth-1:0] cols;
    } aesBlockT;

    // Forward S-box, entry 0 in the most significant byte
    localparam logic [0:255][7:0] SboxTable = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    // Substitutes one byte through the S-box
    function automatic logic [7:0] sbox(input logic [7:0] b);
        return SboxTable[b];
    endfunction

endpackage

// File: hdl/randFunnel.sv
/*
 * Width converter from 128-bit cipher blocks to 32-bit random words.
 * Holds one block and emits its columns most significant first. A new
 * block is taken while the last word leaves, so words follow with no gap.
 */

`timescale 1ns/1ps

module randFunnel import prngPkg::*; (
    input  logic                 Clock,
    input  logic                 arstN,
    input  logic                 inValid,
    output logic                 inReady,
    input  aesBlockT             inBlock,
    output logic                 RandOutValid,
    input  logic                 RandOutReady,
    output logic [RandWidth-1:0] RandOut
);

    aesBlockT                holdBlock;
    logic [WordIdxWidth-1:0] wordIdx;
    logic                    full;
    logic                    wordOut;
    logic                    lastOut;

    assign wordOut = full && RandOutReady;
    assign lastOut = wordOut && (wordIdx == WordIdxWidth'(WordsPerBlock - 1));
    assign inReady = !full || lastOut;

    assign RandOutValid = full;
    assign RandOut      = holdBlock.cols[wordIdx];

    always_ff @(posedge Clock) begin
        if (inValid && inReady) begin
            holdBlock <= inBlock;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            full    <= 1'b0;
            wordIdx <= '0;
        end else if (inValid && inReady) begin
            full    <= 1'b1;
            wordIdx <= '0;
        end else if (lastOut) begin
            // Last word gone and nothing waiting upstream
            full    <= 1'b0;
            wordIdx <= '0;
        end else if (wordOut) begin
            wordIdx <= wordIdx + 1'b1;
        end
    end

endmodule

// File: hdl/seedCounter.sv
/*
 * Plaintext source for the counter-mode generator.
 * Offers successive block numbers, starting at zero after reset, on a
 * valid/ready stream. The count sits in the low half of the block.
 */

`timescale 1ns/1ps

module seedCounter import prngPkg::*; (
    input  logic     Clock,
    input  logic     arstN,
    output logic     seedValid,
    input  logic     seedReady,
    output aesBlockT seed
);

    logic [SeedWidth-1:0] count;

    // Valid comes up one cycle after reset and never drops again
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            count     <= '0;
            seedValid <= 1'b0;
        end else begin
            seedValid <= 1'b1;
            if (seedValid && seedReady) begin
                count <= count + 1'b1;
            end
        end
    end

    assign seed = {{(AesWidth - SeedWidth){1'b0}}, count};

endmodule

// File: prng.f
hdl/prngPkg.sv
hdl/seedCounter.sv
hdl/aesCipher.sv
hdl/blockBuffer.sv
hdl/randFunnel.sv
hdl/prng.sv
testbench/prng_assert.sv
testbench/prngTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the prng testbench with Verilator and runs it.
# Exits with status 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module prngTb -f prng.f -o prngSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/prngSim)
simStatus=$?
echo "$simOutput"

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -q -x "Result: PASSED"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// File: testbench/prngTb.sv
/*
 * Testbench for the AES counter-mode random number generator.
 * Builds the expected word stream with its own AES-128 model, drives
 * RandOutReady on the falling edge and compares every output transfer.
 * Covers reset, full rate, random back-pressure, a long stall and a
 * reset in the middle of the stream.
 */

`timescale 1ns/1ps

module prngTb import prngPkg::*;;

    // The timeout is sized from the words taken over all tests
    localparam int TotalWords = 214;
    localparam int CycleLimit = 40 * TotalWords + 200;
    localparam int RefBlocks  = 64;

    logic                 Clock = 1'b0;
    logic                 arstN;
    logic                 RandOutReady;
    logic                 RandOutValid;
    logic [RandWidth-1:0] RandOut;

    logic [RandWidth-1:0] expQueue [$];
    logic [RandWidth-1:0] heldWord;
    logic [31:0]          lcgState;
    logic                 stalled;
    int                   wordCount;
    int                   errorCount;
    int                   testsPassed;
    int                   testsFailed;
    int                   cycleCount;
    int                   startErrors;

    prng DUT (
        .Clock(Clock), .arstN(arstN), .RandOutReady(RandOutReady),
        .RandOutValid(RandOutValid), .RandOut(RandOut)
    );

    initial begin
        forever #5 Clock = ~Clock;
    end

    // ========================================================================
    // Reference model
    // ========================================================================

    function automatic logic [7:0] gfDouble(input logic [7:0] b);
        return b[7] ? ({b[6:0], 1'b0} ^ 8'h1b) : {b[6:0], 1'b0};
    endfunction

    // Plain AES-128 encryption under AesKey with the state bytes in column order
    function automatic aesBlockT aesRef(input aesBlockT plain);
        aesBlockT   keyBlk;
        aesBlockT   result;
        logic [7:0] w [0:175];
        logic [7:0] s [0:15];
        logic [7:0] t [0:15];
        logic [7:0] tmp [0:3];
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        logic [7:0] rc;
        keyBlk = AesKey;
        rc = 8'h01;
        for (int i = 0; i < 16; i++) begin
            w[i] = keyBlk.bytes[i];
        end
        for (int i = 4; i < 44; i++) begin
            for (int j = 0; j < 4; j++) begin
                tmp[j] = w[4*(i-1) + j];
            end
            if (i % 4 == 0) begin
                tmp[0] = sbox(w[4*(i-1) + 1]) ^ rc;
                tmp[1] = sbox(w[4*(i-1) + 2]);
                tmp[2] = sbox(w[4*(i-1) + 3]);
                tmp[3] = sbox(w[4*(i-1)]);
                rc = gfDouble(rc);
            end
            for (int j = 0; j < 4; j++) begin
                w[4*i + j] = w[4*(i-4) + j] ^ tmp[j];
            end
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = plain.bytes[i] ^ w[i];
        end
        for (int rnd = 1; rnd <= AesRounds; rnd++) begin
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    t[4*c + r] = sbox(s[4*((c + r) % 4) + r]);
                end
            end
            if (rnd != AesRounds) begin
                for (int c = 0; c < 4; c++) begin
                    a0 = t[4*c];
                    a1 = t[4*c + 1];
                    a2 = t[4*c + 2];
                    a3 = t[4*c + 3];
                    t[4*c]     = gfDouble(a0) ^ (gfDouble(a1) ^ a1) ^ a2 ^ a3;
                    t[4*c + 1] = a0 ^ gfDouble(a1) ^ (gfDouble(a2) ^ a2) ^ a3;
                    t[4*c + 2] = a0 ^ a1 ^ gfDouble(a2) ^ (gfDouble(a3) ^ a3);
                    t[4*c + 3] = (gfDouble(a0) ^ a0) ^ a1 ^ a2 ^ gfDouble(a3);
                end
            end
            for (int i = 0; i < 16; i++) begin
                s[i] = t[i] ^ w[16*rnd + i];
            end
        end
        for (int i = 0; i < 16; i++) begin
            result.bytes[i] = s[i];
        end
        return result;
    endfunction

    function automatic logic [31:0] lcgNext(input logic [31:0] cur);
        return cur * 32'd1103515245 + 32'd12345;
    endfunction

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = %h, expected %h", name, actual, expected);
            errorCount++;
        end
    endtask

    // Expected words for counters 0 upward with the most significant column first
    task automatic fillExpected(input int numBlocks);
        aesBlockT             cipher;
        aesBlockT             plain;
        logic [SeedWidth-1:0] counter;
        expQueue.delete();
        for (int b = 0; b < numBlocks; b++) begin
            // The counter fills the low half of the block and the upper half stays zero
            counter = SeedWidth'(b);
            plain = '0;
            plain.cols[2] = counter[SeedWidth-1:RandWidth];
            plain.cols[3] = counter[RandWidth-1:0];
            cipher = aesRef(plain);
            for (int c = 0; c < WordsPerBlock; c++) begin
                expQueue.push_back(cipher.cols[c]);
            end
        end
    endtask

    task automatic applyReset();
        arstN = 1'b0;
        wordCount = 0;
        fillExpected(RefBlocks);
        repeat (4) begin
            @(negedge Clock);
            checkValue("RandOutValid", RandOutValid, 0);
        end
        arstN = 1'b1;
        @(negedge Clock);
        checkValue("RandOutValid", RandOutValid, 0);
    endtask

    task automatic waitWords(input int target);
        while (wordCount < target) begin
            @(negedge Clock);
        end
    endtask

    task automatic endTest(input int num, input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("Test %0d %s: ok", num, name);
            testsPassed++;
        end else begin
            $display("Test %0d %s: %0d errors", num, name, errorCount - errorsBefore);
            testsFailed++;
        end
    endtask

    // ========================================================================
    // Compare process
    // ========================================================================

    always @(posedge Clock) begin
        if (!arstN) begin
            stalled = 1'b0;
        end else begin
            // A stalled word must still be offered unchanged
            if (stalled) begin
                checkValue("RandOutValid", RandOutValid, 1);
                checkValue("RandOut held", RandOut, heldWord);
            end
            if (RandOutValid && RandOutReady) begin
                if (expQueue.size() == 0) begin
                    $display("Output word %0d arrived with no expected value left", wordCount);
                    errorCount++;
                end else begin
                    checkValue("RandOut", RandOut, expQueue.pop_front());
                end
                wordCount++;
            end
            stalled = RandOutValid && !RandOutReady;
            heldWord = RandOut;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
        $display("Result: FAILED");
        $finish;
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        arstN = 1'b0;
        RandOutReady = 1'b0;
        lcgState = 32'd23;
        stalled = 1'b0;
        heldWord = '0;
        wordCount = 0;
        errorCount = 0;
        testsPassed = 0;
        testsFailed = 0;

        startErrors = errorCount;
        applyReset();
        RandOutReady = 1'b1;
        waitWords(4);
        endTest(1, "reset and first block", startErrors);

        startErrors = errorCount;
        waitWords(64);
        endTest(2, "full rate stream", startErrors);

        startErrors = errorCount;
        while (wordCount < 192) begin
            @(negedge Clock);
            lcgState = lcgNext(lcgState);
            RandOutReady = lcgState[16];
        end
        endTest(3, "random back-pressure", startErrors);

        startErrors = errorCount;
        @(negedge Clock);
        RandOutReady = 1'b0;
        repeat (100) @(negedge Clock);
        RandOutReady = 1'b1;
        waitWords(200);
        endTest(4, "long stall", startErrors);

        // Reset lands two words into a block
        startErrors = errorCount;
        waitWords(206);
        applyReset();
        waitWords(8);
        endTest(5, "reset mid-stream", startErrors);

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/prng_assert.sv
/*
 * Handshake assertions on the output stream of the generator.
 * Bound to every prng instance, so the testbench needs no extra wiring.
 */

`timescale 1ns/1ps

module prngAssert import prngPkg::*; (
    input logic                 Clock,
    input logic                 arstN,
    input logic                 RandOutReady,
    input logic                 RandOutValid,
    input logic [RandWidth-1:0] RandOut
);

    validLowInReset: assert property (@(posedge Clock) !arstN |-> !RandOutValid)
        else $error("RandOutValid high during reset");

    // A stalled word keeps its value and its valid
    holdWhileStalled: assert property (@(posedge Clock) disable iff (!arstN)
        (RandOutValid && !RandOutReady) |=> (RandOutValid && $stable(RandOut)))
        else $error("RandOut changed or was withdrawn while stalled");

    noUnknownWord: assert property (@(posedge Clock) disable iff (!arstN)
        RandOutValid |-> !$isunknown(RandOut))
        else $error("RandOut has unknown bits while valid");

endmodule

bind prng prngAssert u_prngAssert (
    .Clock(Clock), .arstN(arstN), .RandOutReady(RandOutReady),
    .RandOutValid(RandOutValid), .RandOut(RandOut)
);
